//--- sd_bridge_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared widths, types and constants for the SD block bridge
// Every bridge module refers to these by scoped name
////////////////////////////////////////////////////////////////////////////

package sd_bridge_pkg;

    // Field widths
    localparam int lba_w        = 32;
    localparam int drive_cnt_w  = 6;
    localparam int host_blk_w   = 5;
    localparam int host_buff_w  = 9;
    localparam int drive_buff_w = 13;
    localparam int img_size_w   = 32;
    localparam int op_w         = 2;

    // Number of host block index bits that select a 512-byte page in the
    // drive buffer
    localparam int page_idx_w = drive_buff_w - host_buff_w;

    // Bit position of the 256-byte page in the drive buffer address
    localparam int page_shift = 8;

    typedef logic [lba_w-1:0]        lba_t;
    typedef logic [drive_cnt_w-1:0]  drive_blk_cnt_t;
    typedef logic [host_blk_w-1:0]   host_blk_t;
    typedef logic [host_buff_w-1:0]  host_buff_addr_t;
    typedef logic [drive_buff_w-1:0] drive_buff_addr_t;
    typedef logic [img_size_w-1:0]   img_size_t;

    // Pending operation with write in bit 1 and read in bit 0
    typedef logic [op_w-1:0] op_t;

    localparam op_t op_none = 2'b00;

    typedef enum logic [2:0] {
        st_idle,
        st_start,
        st_wait_ack,
        st_loop,
        st_next,
        st_done
    } bridge_state_t;

endpackage

//--- blk_ctrl_if.sv
////////////////////////////////////////////////////////////////////////////
// Block bookkeeping link between the transfer FSM and the block counter
// The FSM issues one-cycle strobes and the counter reports the last block
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface blk_ctrl_if;

    // Capture drive address and count at the start of a request
    logic load;
    // One host block has finished
    logic step;
    // Move the host block address to the next block
    logic advance;
    // Abort or reset returns the bookkeeping to zero
    logic clear;
    // Block index has reached the block limit
    logic last;

    modport ctrl (
        output load,
        output step,
        output advance,
        output clear,
        input  last
    );

    modport count (
        input  load,
        input  step,
        input  advance,
        input  clear,
        output last
    );

endinterface

//--- drive_event_detect.sv
////////////////////////////////////////////////////////////////////////////
// Edge detection on the drive requests and the host acknowledge, plus
// the latch that remembers whether a non-empty image is mounted
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module drive_event_detect (
    input  logic                    clk_sys,
    input  logic                    initRESET,
    input  logic                    img_mounted,
    input  logic                    drive_rd,
    input  logic                    drive_wr,
    input  logic                    host_ack,
    input  sd_bridge_pkg::img_size_t img_size,
    output logic                    rd_rise,
    output logic                    wr_rise,
    output logic                    ack_fall,
    output logic                    mounted
);

    logic rd_q;
    logic wr_q;
    logic ack_q;
    logic mount_q;

    // Previous-cycle copies of the level inputs
    always_ff @(posedge clk_sys) begin
        if (initRESET) begin
            rd_q    <= 1'b0;
            wr_q    <= 1'b0;
            ack_q   <= 1'b0;
            mount_q <= 1'b0;
        end else begin
            rd_q    <= drive_rd;
            wr_q    <= drive_wr;
            ack_q   <= host_ack;
            mount_q <= img_mounted;
        end
    end

    // The mount strobe tells us a new image arrived, and a zero size
    // means the slot was emptied
    always_ff @(posedge clk_sys) begin
        if (initRESET) begin
            mounted <= 1'b0;
        end else if (img_mounted && !mount_q) begin
            mounted <= |img_size;
        end
    end

    // Pulses fall in the first cycle the new level is seen
    assign rd_rise  = drive_rd & ~rd_q;
    assign wr_rise  = drive_wr & ~wr_q;
    assign ack_fall = ack_q & ~host_ack;

endmodule

//--- host_block_counter.sv
////////////////////////////////////////////////////////////////////////////
// Host block bookkeeping for the bridge. Tracks which 512-byte block of a
// request is in flight, steps the host block address and maps the host
// buffer byte address into the 13-bit drive buffer
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module host_block_counter (
    input  logic                             clk_sys,
    blk_ctrl_if.count                        ctl,
    input  sd_bridge_pkg::lba_t              drive_lba,
    input  sd_bridge_pkg::drive_blk_cnt_t    drive_blk_cnt,
    input  sd_bridge_pkg::host_buff_addr_t   host_buff_addr,
    output sd_bridge_pkg::lba_t              host_lba,
    output sd_bridge_pkg::drive_buff_addr_t  drive_buff_addr
);

    sd_bridge_pkg::host_blk_t blk_idx;
    sd_bridge_pkg::host_blk_t blk_limit;

    // Drive address was odd, so its data starts half way into the first
    // host block
    logic lba_odd;

    // Block index and limit of the request in flight
    always_ff @(posedge clk_sys) begin
        if (ctl.clear) begin
            blk_idx   <= '0;
            blk_limit <= '0;
        end else if (ctl.load) begin
            blk_idx   <= '0;
            // Two 256-byte drive blocks make one host block
            blk_limit <= drive_blk_cnt[sd_bridge_pkg::drive_cnt_w-1:1];
        end else if (ctl.step) begin
            blk_idx <= blk_idx + sd_bridge_pkg::host_blk_t'(1);
        end
    end

    // Host block address in 512-byte units
    always_ff @(posedge clk_sys) begin
        if (ctl.load) begin
            host_lba <= {1'b0, drive_lba[sd_bridge_pkg::lba_w-1:1]};
            lba_odd  <= drive_lba[0];
        end else if (ctl.advance) begin
            host_lba <= host_lba + sd_bridge_pkg::lba_t'(1);
        end
    end

    assign ctl.last = (blk_idx == blk_limit);

    // Each host block fills the next 512-byte page of the drive buffer.
    // An odd start address shifts everything back by one 256-byte page
    assign drive_buff_addr = {blk_idx[sd_bridge_pkg::page_idx_w-1:0], host_buff_addr}
        - (sd_bridge_pkg::drive_buff_addr_t'(lba_odd) << sd_bridge_pkg::page_shift);

endmodule

//--- sd_bridge_fsm.sv
////////////////////////////////////////////////////////////////////////////
// Transfer FSM of the SD block bridge. Turns one drive request into a run
// of host block transfers and holds the drive acknowledge across them
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sd_bridge_fsm (
    input  logic      clk_sys,
    input  logic      initRESET,
    input  logic      drive_reset_req,
    input  logic      rd_rise,
    input  logic      wr_rise,
    input  logic      ack_fall,
    input  logic      mounted,
    input  logic      drive_rd,
    input  logic      drive_wr,
    input  logic      host_ack,
    blk_ctrl_if.ctrl  ctl,
    output logic      host_rd,
    output logic      host_wr,
    output logic      drive_ack
);

    sd_bridge_pkg::bridge_state_t state;
    sd_bridge_pkg::op_t           op;

    logic abort;
    logic req_rise;

    // Any of these drops the request in progress
    assign abort    = initRESET | drive_reset_req | ~mounted;
    assign req_rise = rd_rise | wr_rise;

    ////////////////////////////////////////////////////////////////////////////
    // Counter strobes
    ////////////////////////////////////////////////////////////////////////////

    assign ctl.clear   = abort;
    assign ctl.load    = ~abort & (state == sd_bridge_pkg::st_idle) & req_rise;
    assign ctl.step    = ~abort & (state == sd_bridge_pkg::st_wait_ack) & ack_fall;
    assign ctl.advance = ~abort & (state == sd_bridge_pkg::st_next);

    ////////////////////////////////////////////////////////////////////////////
    // State register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_sys) begin
        if (initRESET) begin
            state     <= sd_bridge_pkg::st_idle;
            op        <= sd_bridge_pkg::op_none;
            drive_ack <= 1'b0;
            host_rd   <= 1'b0;
            host_wr   <= 1'b0;
        end else if (drive_reset_req || !mounted) begin
            // The host side is left to finish whatever it was doing
            state     <= sd_bridge_pkg::st_idle;
            op        <= sd_bridge_pkg::op_none;
            drive_ack <= 1'b0;
        end else begin
            case (state)
                sd_bridge_pkg::st_idle: begin
                    if (req_rise) begin
                        host_rd   <= drive_rd;
                        host_wr   <= drive_wr;
                        op        <= {drive_wr, drive_rd};
                        state     <= sd_bridge_pkg::st_start;
                    end
                end

                // Host may hold off its acknowledge for as long as it likes
                sd_bridge_pkg::st_start: begin
                    if (host_ack) begin
                        drive_ack <= 1'b1;
                        state     <= sd_bridge_pkg::st_wait_ack;
                    end
                end

                sd_bridge_pkg::st_wait_ack: begin
                    if (ack_fall) begin
                        state <= sd_bridge_pkg::st_loop;
                    end
                end

                // Counter has already stepped by the time we get here
                sd_bridge_pkg::st_loop: begin
                    if (ctl.last) begin
                        op    <= sd_bridge_pkg::op_none;
                        state <= sd_bridge_pkg::st_done;
                    end else begin
                        {host_wr, host_rd} <= sd_bridge_pkg::op_none;
                        state              <= sd_bridge_pkg::st_next;
                    end
                end

                // Host address moves on in this cycle, so the request
                // comes back with the new address
                sd_bridge_pkg::st_next: begin
                    {host_wr, host_rd} <= op;
                    state              <= sd_bridge_pkg::st_start;
                end

                sd_bridge_pkg::st_done: begin
                    drive_ack          <= 1'b0;
                    {host_wr, host_rd} <= op;
                    state              <= sd_bridge_pkg::st_idle;
                end

                default: begin
                    state <= sd_bridge_pkg::st_idle;
                end
            endcase
        end
    end

endmodule

//--- sd_block_bridge.sv
////////////////////////////////////////////////////////////////////////////
// Top level of the bridge between the drive's 256-byte block requests and
// the host's 512-byte SD block interface. Plain ports on both sides
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sd_block_bridge (
    input  logic        clk_sys,
    input  logic        initRESET,
    input  logic        drive_reset_req,

    // Image mount from the host
    input  logic        img_mounted,
    input  logic [31:0] img_size,

    // Drive side, 256-byte blocks
    input  logic        drive_rd,
    input  logic        drive_wr,
    input  logic [31:0] drive_lba,
    input  logic [5:0]  drive_blk_cnt,
    output logic        drive_ack,

    // Host side, 512-byte blocks
    output logic        host_rd,
    output logic        host_wr,
    input  logic        host_ack,
    output logic [31:0] host_lba,
    input  logic [8:0]  host_buff_addr,
    output logic [12:0] drive_buff_addr
);

    logic rd_rise;
    logic wr_rise;
    logic ack_fall;
    logic mounted;

    blk_ctrl_if blk_ctl ();

    ////////////////////////////////////////////////////////////////////////////
    // Edges and mount state
    ////////////////////////////////////////////////////////////////////////////

    drive_event_detect drive_event_detect_inst (
        .clk_sys     (clk_sys),
        .initRESET   (initRESET),
        .img_mounted (img_mounted),
        .drive_rd    (drive_rd),
        .drive_wr    (drive_wr),
        .host_ack    (host_ack),
        .img_size    (img_size),
        .rd_rise     (rd_rise),
        .wr_rise     (wr_rise),
        .ack_fall    (ack_fall),
        .mounted     (mounted)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Transfer control and block bookkeeping
    ////////////////////////////////////////////////////////////////////////////

    sd_bridge_fsm sd_bridge_fsm_inst (
        .clk_sys         (clk_sys),
        .initRESET       (initRESET),
        .drive_reset_req (drive_reset_req),
        .rd_rise         (rd_rise),
        .wr_rise         (wr_rise),
        .ack_fall        (ack_fall),
        .mounted         (mounted),
        .drive_rd        (drive_rd),
        .drive_wr        (drive_wr),
        .host_ack        (host_ack),
        .ctl             (blk_ctl.ctrl),
        .host_rd         (host_rd),
        .host_wr         (host_wr),
        .drive_ack       (drive_ack)
    );

    host_block_counter host_block_counter_inst (
        .clk_sys         (clk_sys),
        .ctl             (blk_ctl.count),
        .drive_lba       (drive_lba),
        .drive_blk_cnt   (drive_blk_cnt),
        .host_buff_addr  (host_buff_addr),
        .host_lba        (host_lba),
        .drive_buff_addr (drive_buff_addr)
    );

endmodule

//--- tb_sd_block_bridge_sva.sv
////////////////////////////////////////////////////////////////////////////
// Handshake checks on the bridge, bound into the top level so they watch
// the host and drive sides of every instance
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module bridge_protocol_checker (
    input logic        clk_sys,
    input logic        initRESET,
    input logic        host_rd,
    input logic        host_wr,
    input logic        host_ack,
    input logic        drive_ack,
    input logic [31:0] host_lba
);

    // One operation at a time on the host side
    assert property (@(posedge clk_sys) disable iff (initRESET)
        !(host_rd && host_wr))
        else $error("host_rd and host_wr are high together");

    // The drive is acknowledged only after the host has answered
    assert property (@(posedge clk_sys) disable iff (initRESET)
        $rose(drive_ack) |-> $past(host_ack))
        else $error("drive_ack rose without host_ack in the cycle before");

    // Host block address holds still while a block is requested
    assert property (@(posedge clk_sys) disable iff (initRESET)
        $changed(host_lba) |-> !$past(host_rd) && !$past(host_wr))
        else $error("host_lba changed while a host request was high");

endmodule

bind sd_block_bridge bridge_protocol_checker protocol_checker_inst (
    .clk_sys   (clk_sys),
    .initRESET (initRESET),
    .host_rd   (host_rd),
    .host_wr   (host_wr),
    .host_ack  (host_ack),
    .drive_ack (drive_ack),
    .host_lba  (host_lba)
);

//--- tb_sd_block_bridge.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the SD block bridge. Replays drive requests from the cases
// file against a host responder model and checks host addressing, buffer
// mapping and the drive acknowledge
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_sd_block_bridge;

    localparam int reset_cycles = 10;
    localparam int max_cases    = 64;
    // The buffer address steps by 7 from 0 to 511, so one acknowledge is 74 cycles
    localparam int addr_stride  = 7;
    localparam int ack_cycles   = 74;
    localparam int hold_cycles  = 20;

    logic        clk_sys = 1'b0;
    logic        initRESET;
    logic        drive_reset_req;
    logic        img_mounted;
    logic [31:0] img_size;
    logic        drive_rd;
    logic        drive_wr;
    logic [31:0] drive_lba;
    logic [5:0]  drive_blk_cnt;
    logic        drive_ack;
    logic        host_rd;
    logic        host_wr;
    logic        host_ack;
    logic [31:0] host_lba;
    logic [8:0]  host_buff_addr;
    logic [12:0] drive_buff_addr;

    int          case_op [max_cases];
    logic [31:0] case_lba [max_cases];
    int          case_cnt [max_cases];
    logic [31:0] case_size [max_cases];
    int          case_rst [max_cases];
    int          case_delay [max_cases];
    int          num_cases;

    // What the host responder should see for the request in flight
    bit          expect_service;
    int          exp_op;
    logic [31:0] exp_half;
    int          exp_odd;
    int          exp_blocks;
    int          exp_delay;
    int          k_base;
    int          blk_k;

    int          mismatches;
    int          failures;
    int          cycles;
    int          cycle_limit;
    int          worst_req;
    logic [31:0] rng = 32'd4;

    always #50 clk_sys = ~clk_sys;

    sd_block_bridge sd_block_bridge_inst (
        .clk_sys         (clk_sys),
        .initRESET       (initRESET),
        .drive_reset_req (drive_reset_req),
        .img_mounted     (img_mounted),
        .img_size        (img_size),
        .drive_rd        (drive_rd),
        .drive_wr        (drive_wr),
        .drive_lba       (drive_lba),
        .drive_blk_cnt   (drive_blk_cnt),
        .drive_ack       (drive_ack),
        .host_rd         (host_rd),
        .host_wr         (host_wr),
        .host_ack        (host_ack),
        .host_lba        (host_lba),
        .host_buff_addr  (host_buff_addr),
        .drive_buff_addr (drive_buff_addr)
    );

    always @(posedge clk_sys) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("Run stopped by the watchdog after %0d cycles", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_word(string name, logic [31:0] actual, logic [31:0] expected);
        assert (actual === expected) else begin
            $display("mismatch at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
            mismatches++;
        end
    endtask

    task automatic require_true(logic cond, string what);
        assert (cond) else begin
            $display("Error at %0t: %s", $time, what);
            failures++;
        end
    endtask

    // One host block from the request to its release
    task automatic serve_block();
        int k;
        int d;
        int hba;
        int n;
        k = blk_k - k_base;
        blk_k++;
        require_true(expect_service && k < exp_blocks, "host request raised with no block due");
        check_word("host_lba", host_lba, exp_half + k);
        check_word("host_rd", 32'(host_rd), 32'(exp_op == 0));
        check_word("host_wr", 32'(host_wr), 32'(exp_op == 1));
        rng = xorshift32(rng);
        d = exp_delay + int'(rng & 32'd3);
        repeat (d) begin
            @(negedge clk_sys);
            check_word("drive_ack", 32'(drive_ack), 32'(k > 0));
        end
        host_ack = 1'b1;
        hba = 0;
        host_buff_addr = 9'd0;
        while (host_ack) begin
            @(negedge clk_sys);
            check_word("drive_ack", 32'(drive_ack), 32'd1);
            check_word("host_rd", 32'(host_rd), 32'(exp_op == 0));
            check_word("host_wr", 32'(host_wr), 32'(exp_op == 1));
            check_word("drive_buff_addr", 32'(drive_buff_addr),
                       (k * 512 + hba - exp_odd * 256) & 8191);
            if (hba == 511) begin
                host_ack = 1'b0;
            end else begin
                hba = hba + addr_stride;
                host_buff_addr = hba[8:0];
            end
        end
        n = 0;
        while ((host_rd || host_wr) && n < 8) begin
            @(negedge clk_sys);
            n++;
        end
        require_true(!(host_rd || host_wr), "host request stayed high after the block");
        check_word("drive_ack", 32'(drive_ack), 32'(k != exp_blocks - 1));
    endtask

    initial begin : host_responder
        host_ack = 1'b0;
        host_buff_addr = 9'd0;
        forever begin
            @(negedge clk_sys);
            if (host_rd || host_wr) begin
                serve_block();
            end
        end
    end

    initial begin : main_sequence
        int          fd;
        int          code;
        string       line;
        int          f_op;
        int          f_cnt;
        int          f_rst;
        int          f_delay;
        logic [31:0] f_lba;
        logic [31:0] f_size;
        int          max_delay;
        int          n;
        bit          started;

        initRESET = 1'b1;
        drive_reset_req = 1'b0;
        img_mounted = 1'b0;
        img_size = 32'd0;
        drive_rd = 1'b0;
        drive_wr = 1'b0;
        drive_lba = 32'd0;
        drive_blk_cnt = 6'd0;
        num_cases = 0;
        max_delay = 0;
        k_base = 0;
        blk_k = 0;

        fd = $fopen("sd_block_bridge_cases.txt", "r");
        require_true(fd != 0, "the cases file could not be opened");
        if (fd != 0) begin
            while (!$feof(fd) && num_cases < max_cases) begin
                code = $fgets(line, fd);
                if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
                    code = $sscanf(line, "%d %h %d %h %d %d",
                                   f_op, f_lba, f_cnt, f_size, f_rst, f_delay);
                    if (code == 6) begin
                        case_op[num_cases] = f_op;
                        case_lba[num_cases] = f_lba;
                        case_cnt[num_cases] = f_cnt;
                        case_size[num_cases] = f_size;
                        case_rst[num_cases] = f_rst;
                        case_delay[num_cases] = f_delay;
                        num_cases++;
                        if (f_delay > max_delay) begin
                            max_delay = f_delay;
                        end
                    end
                end
            end
            $fclose(fd);
        end
        require_true(num_cases > 0, "no requests were read from the cases file");

        // Longest request is 31 host blocks, plus mount and settling cycles
        worst_req = 31 * (max_delay + 3 + ack_cycles + 8) + hold_cycles + 20;
        cycle_limit = reset_cycles + num_cases * worst_req + 20;

        repeat (reset_cycles) @(negedge clk_sys);
        initRESET = 1'b0;
        @(negedge clk_sys);
        check_word("host_rd", 32'(host_rd), 32'd0);
        check_word("host_wr", 32'(host_wr), 32'd0);
        check_word("drive_ack", 32'(drive_ack), 32'd0);

        for (int i = 0; i < num_cases; i++) begin
            img_mounted = 1'b1;
            img_size = case_size[i];
            @(negedge clk_sys);
            img_mounted = 1'b0;
            drive_reset_req = (case_rst[i] != 0);
            @(negedge clk_sys);
            expect_service = (case_size[i] != 0) && (case_rst[i] == 0);
            exp_op = case_op[i];
            exp_half = case_lba[i] >> 1;
            exp_odd = int'(case_lba[i] & 32'd1);
            exp_blocks = case_cnt[i] / 2;
            exp_delay = case_delay[i];
            k_base = blk_k;
            drive_lba = case_lba[i];
            drive_blk_cnt = case_cnt[i][5:0];
            drive_rd = (case_op[i] == 0);
            drive_wr = (case_op[i] == 1);
            started = 1'b0;
            n = 0;
            if (expect_service) begin
                // Completion is the fall of drive_ack after its rise
                while (!(started && !drive_ack) && n < worst_req) begin
                    @(negedge clk_sys);
                    n++;
                    if (drive_ack) begin
                        started = 1'b1;
                    end
                end
                require_true(started && !drive_ack, "drive request did not complete in time");
                check_word("host transfers", blk_k - k_base, exp_blocks);
            end else begin
                repeat (hold_cycles) begin
                    @(negedge clk_sys);
                    check_word("host_rd", 32'(host_rd), 32'd0);
                    check_word("host_wr", 32'(host_wr), 32'd0);
                    check_word("drive_ack", 32'(drive_ack), 32'd0);
                end
            end
            drive_rd = 1'b0;
            drive_wr = 1'b0;
            @(negedge clk_sys);
            drive_reset_req = 1'b0;
            repeat (6) @(negedge clk_sys);
        end

        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- sd_block_bridge_cases.txt
# op: 0 read, 1 write | drive_lba hex | block count, even 2..62 | img_size hex
# drive_reset_req held 0/1 | base host acknowledge delay in cycles
0 00000000 2 00100000 0 0
0 00000010 4 00100000 0 2
1 00000020 2 00100000 0 1
1 00000101 6 00100000 0 3
0 00000007 8 00100000 0 0
1 00000abc 10 00100000 0 4
0 00000040 4 00000000 0 1
1 00000040 4 00000000 0 0
0 00000040 4 00100000 0 1
1 00000080 2 00100000 1 0
0 00000081 4 00100000 1 2
1 00000080 2 00100000 0 0
0 0001fffe 32 00100000 0 1
1 00001235 16 00200000 0 2
0 fffffff0 6 00100000 0 0
1 ffffffff 4 00100000 0 1
0 00000333 62 00100000 0 0
1 00000400 62 00100000 0 2
0 00000002 2 00000001 0 5
1 00000003 2 00100000 0 0

//--- sd_block_bridge.f
sd_bridge_pkg.sv
blk_ctrl_if.sv
drive_event_detect.sv
host_block_counter.sv
sd_bridge_fsm.sv
sd_block_bridge.sv
tb_sd_block_bridge_sva.sv
tb_sd_block_bridge.sv

//--- Makefile
# Verilator build and run of the SD block bridge testbench

SIM := obj_dir/Vtb_sd_block_bridge

.PHONY: all run clean

all: run

$(SIM): sd_block_bridge.f $(shell cat sd_block_bridge.f)
	verilator --binary --timing --assert -f sd_block_bridge.f --top-module tb_sd_block_bridge

run: $(SIM) sd_block_bridge_cases.txt
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf obj_dir
